/* common/can_ts_defs.svh */
// build-time constants; FIFO depth must be a power of two, idle run is bits times clocks per bit
`ifndef CAN_TS_DEFS_SVH
`define CAN_TS_DEFS_SVH

// clock cycles per timestamp tick
`define CAN_TS_PRESCALER 10

// clock cycles per CAN bit, no sample point logic
`define CAN_TS_BIT_CLKS 4

// end of frame plus intermission
`define CAN_TS_IDLE_BITS 11

// records held before overflow
`define CAN_TS_FIFO_DEPTH 4

`endif

/* common/can_ts_pkg.sv */
// shared types only; the record layout is fixed at 80 bits, edge count saturates at 16 bits
`default_nettype none

package can_ts_pkg;

  // free-running timestamp, wraps at 32 bits
  typedef logic [31:0] ts_t;

  // bus monitor states
  typedef enum logic [1:0] {
    mon_wait_idle = 2'd0,
    mon_idle      = 2'd1,
    mon_in_frame  = 2'd2
  } mon_state_e;

  // one record per frame, start time in the top word
  typedef struct packed {
    ts_t         sof_ts;
    ts_t         eof_ts;
    logic [15:0] edge_count;
  } ts_record_t;

endpackage

`default_nettype wire

/* timestamp/carry_lookahead_adder.sv */
// 32-bit adder built from 4-bit lookahead groups with a rippled group carry; purely combinational
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead_adder
  import can_ts_pkg::*;
(
  input  ts_t  a,
  input  ts_t  b,
  input  logic cin,
  output ts_t  sum,
  output logic cout
);

  ts_t         p;
  ts_t         g;
  logic [32:0] c;

  assign p = a ^ b;
  assign g = a & b;

  assign c[0] = cin;

  // carries inside a group depend only on the group carry in
  for (genvar grp = 0; grp < 8; grp++) begin : g_grp
    localparam int B = grp * 4;
    logic grp_g;
    logic grp_p;

    assign c[B+1] = g[B] | (p[B] & c[B]);
    assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & c[B]);
    assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                  | (p[B+2] & p[B+1] & p[B] & c[B]);

    // group generate and propagate
    assign grp_g = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                 | (p[B+3] & p[B+2] & p[B+1] & g[B]);
    assign grp_p = p[B+3] & p[B+2] & p[B+1] & p[B];

    assign c[B+4] = grp_g | (grp_p & c[B]);
  end

  assign sum  = p ^ c[31:0];
  assign cout = c[32];

endmodule

`default_nettype wire

/* timestamp/can_timestamp_generator.sv */
// timestamp ticks every CAN_TS_PRESCALER clocks and wraps; record is pushed one cycle after frame end
`timescale 1ns/1ps
`default_nettype none

`include "can_ts_defs.svh"

module can_timestamp_generator
  import can_ts_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       frame_start,
  input  logic       frame_end,
  input  logic       rx_edge,
  output ts_t        current_timestamp,
  output logic       rec_push,
  output ts_record_t rec_in
);

  localparam int PRESCALER = `CAN_TS_PRESCALER;
  localparam int PRESC_W = (PRESCALER > 1) ? $clog2(PRESCALER) : 1;

  logic [PRESC_W-1:0] presc_cnt;
  logic               presc_wrap;
  ts_t                next_timestamp;
  ts_t                sof_ts;
  logic [15:0]        edge_cnt;

  assign presc_wrap = (presc_cnt == PRESC_W'(PRESCALER - 1));

  // increment by one, carry out unused since the counter wraps
  carry_lookahead_adder i_inc (
    .a    (current_timestamp),
    .b    (ts_t'(1)),
    .cin  (1'b0),
    .sum  (next_timestamp),
    .cout ()
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_cnt         <= '0;
      current_timestamp <= '0;
      rec_push          <= 1'b0;
    end else begin
      if (presc_wrap) begin
        presc_cnt         <= '0;
        current_timestamp <= next_timestamp;
      end else begin
        presc_cnt <= presc_cnt + 1'b1;
      end
      rec_push <= frame_end;
    end
  end

  // per-frame capture; the start edge arrives with frame_start
  always_ff @(posedge clk) begin
    if (frame_start) begin
      sof_ts   <= current_timestamp;
      edge_cnt <= {15'd0, rx_edge};
    end else if (rx_edge && (edge_cnt != 16'hffff)) begin
      edge_cnt <= edge_cnt + 16'd1;
    end
    if (frame_end) begin
      rec_in.sof_ts     <= sof_ts;
      rec_in.eof_ts     <= current_timestamp;
      rec_in.edge_count <= edge_cnt;
    end
  end

endmodule

`default_nettype wire

/* source/can_bus_monitor.sv */
// frame boundaries from recessive clock counts only; no bit sampling, destuffing or error frames
`timescale 1ns/1ps
`default_nettype none

`include "can_ts_defs.svh"

module can_bus_monitor
  import can_ts_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic can_rx,
  output logic frame_start,
  output logic frame_end,
  output logic rx_edge
);

  localparam int IDLE_CLKS = `CAN_TS_IDLE_BITS * `CAN_TS_BIT_CLKS;
  localparam int RUN_W = $clog2(IDLE_CLKS + 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             rx_toggle;
  logic             rx_fall;
  logic             idle_hit;
  logic [RUN_W-1:0] run_cnt;
  mon_state_e       state;

  // two-flop synchronizer, plus one stage for edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= can_rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign rx_toggle = rx_sync ^ rx_prev;
  assign rx_fall   = rx_prev & ~rx_sync;

  // run reaches IDLE_CLKS on the edge that sees this
  assign idle_hit = rx_sync && (run_cnt == RUN_W'(IDLE_CLKS - 1));

  // recessive run length, saturating
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_cnt <= '0;
    end else if (!rx_sync) begin
      run_cnt <= '0;
    end else if (run_cnt != RUN_W'(IDLE_CLKS)) begin
      run_cnt <= run_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= mon_wait_idle;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      rx_edge     <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      rx_edge     <= 1'b0;
      case (state)
        mon_wait_idle: begin
          // frame in progress at reset is skipped
          if (idle_hit) begin
            state <= mon_idle;
          end
        end
        mon_idle: begin
          if (rx_fall) begin
            state       <= mon_in_frame;
            frame_start <= 1'b1;
            rx_edge     <= 1'b1;
          end
        end
        mon_in_frame: begin
          rx_edge <= rx_toggle;
          if (idle_hit) begin
            state     <= mon_idle;
            frame_end <= 1'b1;
          end
        end
        default: begin
          state <= mon_wait_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/ts_record_fifo.sv */
// CAN_TS_FIFO_DEPTH must be a power of two; pushes into a full FIFO are dropped, overflow is sticky
`timescale 1ns/1ps
`default_nettype none

`include "can_ts_defs.svh"

module ts_record_fifo
  import can_ts_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  ts_record_t din,
  input  logic       pop,
  output ts_record_t dout,
  output logic       not_empty,
  output logic       overflow
);

  localparam int DEPTH = `CAN_TS_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  ts_record_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  assign full      = (count == (PTR_W + 1)'(DEPTH));
  assign not_empty = (count != '0);
  assign do_pop    = pop && not_empty;
  // full plus pop frees the head slot in the same cycle
  assign do_push   = push && (!full || do_pop);

  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // dropped record
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/can_timestamp_unit.sv */
// can_rx is asynchronous with recessive high; rd pops only while rec_valid is high
`timescale 1ns/1ps
`default_nettype none

module can_timestamp_unit
  import can_ts_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       can_rx,
  input  logic       rd,
  output ts_t        current_timestamp,
  output ts_record_t rec,
  output logic       rec_valid,
  output logic       overflow
);

  logic       frame_start;
  logic       frame_end;
  logic       rx_edge;
  logic       rec_push;
  ts_record_t rec_in;

  can_bus_monitor i_monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .can_rx      (can_rx),
    .frame_start (frame_start),
    .frame_end   (frame_end),
    .rx_edge     (rx_edge)
  );

  can_timestamp_generator i_generator (
    .clk               (clk),
    .rst_n             (rst_n),
    .frame_start       (frame_start),
    .frame_end         (frame_end),
    .rx_edge           (rx_edge),
    .current_timestamp (current_timestamp),
    .rec_push          (rec_push),
    .rec_in            (rec_in)
  );

  // head record drives the outputs directly
  ts_record_fifo i_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (rec_push),
    .din       (rec_in),
    .pop       (rd),
    .dout      (rec),
    .not_empty (rec_valid),
    .overflow  (overflow)
  );

endmodule

`default_nettype wire

/* tb/tb_can_timestamp_unit.sv */
// directed tests; can_rx and rd change 2 ns after a rising edge and expected times count those edges
`timescale 1ns/1ps
`default_nettype none

`include "can_ts_defs.svh"

module tb_can_timestamp_unit
  import can_ts_pkg::*;
  ();

  localparam int CLK_PERIOD = 20;
  localparam int PRESCALER  = `CAN_TS_PRESCALER;
  localparam int BIT_CLKS   = `CAN_TS_BIT_CLKS;
  localparam int IDLE_CLKS  = `CAN_TS_IDLE_BITS * `CAN_TS_BIT_CLKS;
  localparam int DEPTH      = `CAN_TS_FIFO_DEPTH;
  localparam int RESET_CLKS = 16;
  // two synchronizer flops, then the pulse register
  localparam int SYNC_LAT   = 2;
  localparam int START_LAT  = 3;
  localparam int BODY_BITS  = 24;
  localparam int GAP_CLKS   = SYNC_LAT + IDLE_CLKS + 4;
  localparam int FRAME_CLKS = (BODY_BITS + 1) * BIT_CLKS + GAP_CLKS;
  localparam int RATE_CLKS  = 2600;
  localparam int NUM_FRAMES = 12;
  localparam int TEST_CLKS  = RATE_CLKS + NUM_FRAMES * FRAME_CLKS + 2 * RESET_CLKS + 4 * DEPTH;
  localparam int WATCHDOG_CLKS = TEST_CLKS + 500;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        can_rx;
  logic        rd;
  ts_t         current_timestamp;
  ts_record_t  rec;
  logic        rec_valid;
  logic        overflow;

  int unsigned edge_n;
  int          errors;
  logic [15:0] lfsr;
  int          frame_edges;
  int unsigned last_rise_n;
  ts_record_t  exp_q[$];

  can_timestamp_unit i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .can_rx            (can_rx),
    .rd                (rd),
    .current_timestamp (current_timestamp),
    .rec               (rec),
    .rec_valid         (rec_valid),
    .overflow          (overflow)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // edges since reset release give the reference for all timestamps
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edge_n <= 0;
    end else begin
      edge_n <= edge_n + 1;
    end
  end

  function automatic ts_t model_ts(input int unsigned n);
    return ts_t'(n / PRESCALER);
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hb400;
    end
    return s >> 1;
  endfunction

  task automatic fail_run(input string line);
    errors++;
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_ts(input ts_t got, input ts_t want, input string what);
    if (got !== want) begin
      fail_run($sformatf("error at %0d ns: %s is %0d, expected %0d",
                         $time, what, got, want));
    end
  endtask

  task automatic check_rec(input ts_record_t got, input ts_record_t want, input string what);
    if (got !== want) begin
      fail_run($sformatf("error at %0d ns: %s is %0d/%0d/%0d, expected %0d/%0d/%0d",
                         $time, what, got.sof_ts, got.eof_ts, got.edge_count,
                         want.sof_ts, want.eof_ts, want.edge_count));
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      fail_run($sformatf("error at %0d ns: %s is %b, expected %b", $time, what, got, want));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic apply_reset(input logic rx_level);
    rst_n  = 1'b0;
    can_rx = rx_level;
    rd     = 1'b0;
    wait_cycles(RESET_CLKS);
    rst_n = 1'b1;
  endtask

  // one bit time on the line while counting the edges driven
  task automatic drive_bit(input logic level);
    if (level != can_rx) begin
      frame_edges++;
      if (level) begin
        last_rise_n = edge_n;
      end
    end
    can_rx = level;
    wait_cycles(BIT_CLKS);
  endtask

  task automatic send_frame();
    int unsigned sof_n;
    int          ones;
    logic        level;
    ts_record_t  want;
    frame_edges = 0;
    ones = 0;
    sof_n = edge_n;
    drive_bit(1'b0);
    for (int i = 1; i < BODY_BITS; i++) begin
      if (ones == 5) begin
        // forced dominant keeps recessive runs short of idle
        level = 1'b0;
      end else begin
        level = lfsr[0];
        lfsr  = lfsr_next(lfsr);
      end
      ones = level ? ones + 1 : 0;
      drive_bit(level);
    end
    drive_bit(1'b1);
    want.sof_ts     = model_ts(sof_n + START_LAT);
    want.eof_ts     = model_ts(last_rise_n + SYNC_LAT + IDLE_CLKS);
    want.edge_count = 16'(frame_edges);
    exp_q.push_back(want);
    wait_cycles(GAP_CLKS);
  endtask

  task automatic wait_rec_valid(input int max_clks);
    int n;
    n = 0;
    while (rec_valid !== 1'b1) begin
      if (n == max_clks) begin
        fail_run("timeout: no record showed up on rec_valid");
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic pop_record();
    rd = 1'b1;
    next_cycle();
    rd = 1'b0;
  endtask

  task automatic test_timestamp_rate();
    apply_reset(1'b1);
    for (int i = 0; i < RATE_CLKS; i++) begin
      check_ts(current_timestamp, model_ts(edge_n), "current_timestamp");
      next_cycle();
    end
  endtask

  task automatic test_startup_guard();
    // line already dominant while reset is held
    apply_reset(1'b0);
    drive_bit(1'b1);
    drive_bit(1'b0);
    drive_bit(1'b1);
    drive_bit(1'b0);
    drive_bit(1'b1);
    wait_cycles(GAP_CLKS);
    check_flag(rec_valid, 1'b0, "rec_valid after frame cut by reset");
    send_frame();
    wait_rec_valid(GAP_CLKS);
    check_rec(rec, exp_q.pop_front(), "first record after reset");
    pop_record();
  endtask

  task automatic test_single_frame();
    send_frame();
    wait_rec_valid(GAP_CLKS);
    check_rec(rec, exp_q.pop_front(), "single frame record");
    pop_record();
    check_flag(rec_valid, 1'b0, "rec_valid after single read");
  endtask

  task automatic test_queue_order();
    ts_t        prev_sof;
    ts_record_t held;
    for (int i = 0; i < DEPTH; i++) begin
      send_frame();
    end
    wait_rec_valid(GAP_CLKS);
    prev_sof = '0;
    for (int i = 0; i < DEPTH; i++) begin
      check_flag(rec.sof_ts > prev_sof, 1'b1, "sof_ts rising");
      prev_sof = rec.sof_ts;
      check_rec(rec, exp_q.pop_front(), "queued record");
      pop_record();
    end
    check_flag(rec_valid, 1'b0, "rec_valid after last read");
    held = rec;
    pop_record();
    check_flag(rec_valid, 1'b0, "rec_valid after read of empty FIFO");
    check_flag(overflow, 1'b0, "overflow after read of empty FIFO");
    check_rec(rec, held, "head after read of empty FIFO");
  endtask

  task automatic test_overflow();
    check_flag(overflow, 1'b0, "overflow before filling");
    for (int i = 0; i <= DEPTH; i++) begin
      send_frame();
    end
    // fifth record never enters the FIFO
    void'(exp_q.pop_back());
    check_flag(overflow, 1'b1, "overflow after fifth frame");
    for (int i = 0; i < DEPTH; i++) begin
      check_rec(rec, exp_q.pop_front(), "record kept on overflow");
      pop_record();
    end
    check_flag(rec_valid, 1'b0, "rec_valid after draining");
    check_flag(overflow, 1'b1, "overflow after draining");
  endtask

  initial begin
    rst_n  = 1'b0;
    can_rx = 1'b1;
    rd     = 1'b0;
    errors = 0;
    lfsr   = 16'd52;
    test_timestamp_rate();
    test_startup_guard();
    test_single_frame();
    test_queue_order();
    test_overflow();
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CLKS * CLK_PERIOD);
    $display("timeout: tests still running after %0d clock cycles", WATCHDOG_CLKS);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* can_ts.f */
+incdir+common
common/can_ts_pkg.sv
timestamp/carry_lookahead_adder.sv
timestamp/can_timestamp_generator.sv
source/can_bus_monitor.sv
source/ts_record_fifo.sv
source/can_timestamp_unit.sv
tb/tb_can_timestamp_unit.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_can_timestamp_unit
LOG=sim.log

verilator --binary --timing -f can_ts.f --top-module "$TOP" -o "$TOP"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation passed"
exit 0
